// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator and run, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mips_tb -Mdir obj_dir -f vlog.f \
  && ./obj_dir/Vmips_tb \
  || { echo "build or simulation failed" >&2; exit 1; }

// ==== src/alu.sv ====
`timescale 1ns/100ps

module alu import mips_pkg::*; (
  input  alu_op_t     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [4:0]  shamt,
  output logic [31:0] result,
  output logic        zero
);

  logic [31:0] sum;
  logic [31:0] diff;
  logic        less; // signed a < b

  assign sum  = a + b;  // wraps
  assign diff = a - b;
  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = {31'b0, less};
      ALU_SLL: result = b << shamt;      // shift amount from instr rather than rs
      ALU_LUI: result = {b[15:0], 16'h0000};
      default: result = 32'h0000_0000;
    endcase
  end

  // used for beq/bne with ALU_SUB
  assign zero = (result == 32'h0000_0000);

endmodule

// ==== src/controller.sv ====
`timescale 1ns/100ps

module controller import mips_pkg::*; (
  input  instr_u  instr,
  ctrl_if.ctl     ctl,
  output logic    data_read,
  output logic    data_write
);

  opcode_t op;
  funct_t  funct;

  assign op    = instr.r_fields.op;
  assign funct = instr.r_fields.funct;

  always_comb begin
    // defaults give no write, no memory access and a plain pc+4
    ctl.reg_write    = 1'b0;
    ctl.reg_dst      = 1'b0;
    ctl.alu_src      = 1'b0;
    ctl.mem_to_reg   = 1'b0;
    ctl.branch       = 1'b0;
    ctl.branch_ne    = 1'b0;
    ctl.jump         = 1'b0;
    ctl.jump_reg     = 1'b0;
    ctl.imm_zero_ext = 1'b0;
    ctl.alu_op       = ALU_ADD;
    data_read        = 1'b0;
    data_write       = 1'b0;

    case (op)
      OP_SPECIAL: begin
        ctl.reg_dst = 1'b1; // r-type writes rd
        case (funct)
          FN_ADDU: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_ADD;
          end
          FN_SUBU: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_SUB;
          end
          FN_AND: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_AND;
          end
          FN_OR: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_OR;
          end
          FN_XOR: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_XOR;
          end
          FN_SLT: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_SLT;
          end
          FN_SLL: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_SLL; // shifts rt and ignores rs
          end
          FN_JR:   ctl.jump_reg = 1'b1; // no register write
          default: ;                    // unknown funct acts as nop
        endcase
      end
      OP_ADDIU: begin
        ctl.reg_write = 1'b1;
        ctl.alu_src   = 1'b1; // sign-extended imm
      end
      OP_ANDI: begin
        ctl.reg_write    = 1'b1;
        ctl.alu_src      = 1'b1;
        ctl.imm_zero_ext = 1'b1;
        ctl.alu_op       = ALU_AND;
      end
      OP_ORI: begin
        ctl.reg_write    = 1'b1;
        ctl.alu_src      = 1'b1;
        ctl.imm_zero_ext = 1'b1;
        ctl.alu_op       = ALU_OR;
      end
      OP_LUI: begin
        ctl.reg_write    = 1'b1;
        ctl.alu_src      = 1'b1;
        ctl.imm_zero_ext = 1'b1;
        ctl.alu_op       = ALU_LUI;
      end
      OP_LW: begin
        ctl.reg_write  = 1'b1;
        ctl.alu_src    = 1'b1; // base + offset
        ctl.mem_to_reg = 1'b1;
        data_read      = 1'b1;
      end
      OP_SW: begin
        ctl.alu_src = 1'b1;
        data_write  = 1'b1;
      end
      OP_BEQ: begin
        ctl.branch = 1'b1;
        ctl.alu_op = ALU_SUB; // zero flag compares rs and rt
      end
      OP_BNE: begin
        ctl.branch_ne = 1'b1;
        ctl.alu_op    = ALU_SUB;
      end
      OP_J:    ctl.jump = 1'b1;
      default: ; // unknown opcode acts as nop
    endcase
  end

endmodule

// ==== src/ctrl_if.sv ====
`timescale 1ns/100ps

// decoded control bundle from controller to datapath
interface ctrl_if import mips_pkg::*; ();
  logic    reg_write;    // commit result to register file
  logic    reg_dst;      // high selects rd, low selects rt
  logic    alu_src;      // high puts the immediate on alu b
  logic    mem_to_reg;   // writeback from load data
  logic    branch;       // beq
  logic    branch_ne;    // bne
  logic    jump;         // j with pseudo-direct target
  logic    jump_reg;     // jr takes its target from rs
  logic    imm_zero_ext; // andi/ori/lui
  alu_op_t alu_op;

  modport ctl (
    output reg_write, reg_dst, alu_src, mem_to_reg, branch, branch_ne,
    output jump, jump_reg, imm_zero_ext, alu_op
  );

  modport dp (
    input reg_write, reg_dst, alu_src, mem_to_reg, branch, branch_ne,
    input jump, jump_reg, imm_zero_ext, alu_op
  );
endinterface

// ==== src/datapath.sv ====
`timescale 1ns/100ps

module datapath import mips_pkg::*; #(
  parameter logic [31:0] reset_vector = 32'hBFC00000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  instr_u      instr,
  input  logic [31:0] data_readdata,
  ctrl_if.dp          ctl,
  output logic [31:0] instr_address,
  output logic [31:0] data_address,
  output logic [31:0] data_writedata,
  output logic [31:0] register_v0
);

  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] pc_next;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic        branch_taken;

  logic [31:0] imm_ext;
  logic [4:0]  write_reg;
  logic [31:0] write_data;
  logic [31:0] rs_value;
  logic [31:0] rt_value;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        alu_zero;

  // program counter holds while stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
    end else if (clk_enable) begin
      pc <= pc_next;
    end
  end

  assign instr_address = pc;
  assign pc_plus4      = pc + 32'd4;

  // immediate extension
  assign imm_ext = ctl.imm_zero_ext ? {16'h0000, instr.i_fields.imm}
                                    : {{16{instr.i_fields.imm[15]}}, instr.i_fields.imm};

  // next-address candidates
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j_fields.target, 2'b00};

  // zero flag only tested here
  assign branch_taken = (ctl.branch & alu_zero) | (ctl.branch_ne & ~alu_zero);

  always_comb begin
    if (ctl.jump_reg) begin
      pc_next = rs_value;         // jr also serves the halt at 0
    end else if (ctl.jump) begin
      pc_next = jump_target;
    end else if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  assign write_reg = ctl.reg_dst ? instr.r_fields.rd : instr.i_fields.rt;

  reg_file regs (
    .clk          (clk),
    .reset        (reset),
    .write_enable (ctl.reg_write & clk_enable), // no commit while stalled
    .read_addr_a  (instr.r_fields.rs),
    .read_addr_b  (instr.r_fields.rt),
    .write_addr   (write_reg),
    .write_data   (write_data),
    .read_data_a  (rs_value),
    .read_data_b  (rt_value),
    .register_v0  (register_v0)
  );

  assign alu_b = ctl.alu_src ? imm_ext : rt_value;

  alu alu_inst (
    .op     (ctl.alu_op),
    .a      (rs_value),
    .b      (alu_b),
    .shamt  (instr.r_fields.shamt),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // data memory side
  assign data_address   = alu_result; // base + offset for lw/sw
  assign data_writedata = rt_value;

  // writeback select
  assign write_data = ctl.mem_to_reg ? data_readdata : alu_result;

endmodule

// ==== src/mips_cpu_harvard.sv ====
`timescale 1ns/100ps

module mips_cpu_harvard #(
  parameter logic [31:0] reset_vector = 32'hBFC00000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,    // low stalls pc and registers

  output logic [31:0] instr_address, // current pc
  input  logic [31:0] instr_readdata, // same-cycle instruction

  output logic [31:0] data_address,
  output logic        data_read,
  output logic        data_write,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata,

  output logic [31:0] register_v0,
  output logic        active
);

  // decoded controls between the two halves
  ctrl_if ctl ();

  controller control (
    .instr      (instr_readdata),
    .ctl        (ctl.ctl),
    .data_read  (data_read),  // straight to the ports
    .data_write (data_write)
  );

  datapath #(
    .reset_vector (reset_vector)
  ) datap (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .instr          (instr_readdata),
    .data_readdata  (data_readdata),
    .ctl            (ctl.dp),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .register_v0    (register_v0)
  );

  // active is set by reset and drops once pc hits 0
  // a stalled edge also clears it
  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b1;
    end else if (clk_enable) begin
      active <= (instr_address != 32'h0000_0000);
    end else begin
      active <= 1'b0;
    end
  end

endmodule

// ==== src/mips_pkg.sv ====
package mips_pkg;

  // subset of the major opcodes
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, // r-type decoded by funct
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // funct field for OP_SPECIAL
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, // wraps without overflow trap
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT, // signed compare
    ALU_SLL, // b shifted by shamt
    ALU_LUI  // b low half to upper half
  } alu_op_t;

  // three views of one instruction word
  typedef struct packed {
    opcode_t    op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_type_t;

  typedef struct packed {
    opcode_t     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_type_t;

  typedef struct packed {
    opcode_t     op;
    logic [25:0] target; // word index within 256MB region
  } j_type_t;

  typedef union packed {
    r_type_t r_fields;
    i_type_t i_fields;
    j_type_t j_fields;
  } instr_u;

endpackage

// ==== src/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic        clk,
  input  logic        reset,
  input  logic        write_enable, // already gated by clk_enable
  input  logic [4:0]  read_addr_a,
  input  logic [4:0]  read_addr_b,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  output logic [31:0] read_data_a,
  output logic [31:0] read_data_b,
  output logic [31:0] register_v0
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0000_0000;
      end
    end else if (write_enable && write_addr != 5'd0) begin // $zero stays 0
      regs[write_addr] <= write_data;
    end
  end

  // combinational reads within the same cycle
  assign read_data_a = regs[read_addr_a];
  assign read_data_b = regs[read_addr_b];

  assign register_v0 = regs[2]; // $v0

endmodule

// ==== verification/mips_cpu_checker.sv ====
`timescale 1ns/100ps

module mips_cpu_checker #(
  parameter logic [31:0] reset_vector = 32'hBFC00000
) (
  input logic        clk,
  input logic        reset,
  input logic        clk_enable,
  input logic [31:0] instr_address,
  input logic [31:0] data_address,
  input logic        data_read,
  input logic        data_write,
  input logic        active
);

  // first edge after release still shows the reset state
  property reset_state;
    @(posedge clk) $fell(reset) |-> (instr_address == reset_vector && active);
  endproperty

  property stall_holds_pc;
    @(posedge clk) disable iff (reset) !clk_enable |=> $stable(instr_address);
  endproperty

  property strobes_exclusive;
    @(posedge clk) disable iff (reset) !(data_read && data_write);
  endproperty

  // lw and sw are word accesses
  property access_aligned;
    @(posedge clk) disable iff (reset)
      (data_read || data_write) |-> (data_address[1:0] == 2'b00);
  endproperty

  property halt_stays_inactive;
    @(posedge clk) disable iff (reset)
      (!active && instr_address == 32'h0000_0000) |=> !active;
  endproperty

  reset_check: assert property (reset_state)
    else $error("pc or active wrong on the first edge after reset");
  stall_check: assert property (stall_holds_pc)
    else $error("instr_address moved across a stalled edge");
  strobe_check: assert property (strobes_exclusive)
    else $error("data_read and data_write high together");
  align_check: assert property (access_aligned)
    else $error("data_address not word aligned during an access");
  halt_check: assert property (halt_stays_inactive)
    else $error("active rose again at pc 0 without a reset");

endmodule

// ==== verification/mips_tb.sv ====
`timescale 1ns/100ps

module mips_tb import mips_pkg::*; ();

  localparam logic [31:0] reset_vector   = 32'hBFC00000;
  localparam int          timeout_cycles = 2000;
  localparam logic [31:0] halt_word      = {OP_SPECIAL, 20'h00000, FN_JR}; // jr $zero

  logic        clk        = 1'b0;
  logic        reset      = 1'b1; // held from time 0
  logic        clk_enable = 1'b0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_read;
  logic        data_write;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;
  logic [31:0] register_v0;
  logic        active;

  logic [31:0] rom [32];  // program image at reset_vector
  logic [31:0] ram [256]; // data words indexed by byte address bits 9:2
  logic [31:0] rom_offset;
  logic [31:0] operand_a; // random words placed at 0x100 and 0x104
  logic [31:0] operand_b;

  always #50 clk = ~clk; // 100 ns period

  // combinational instruction rom reads nop outside the image
  assign rom_offset     = instr_address - reset_vector;
  assign instr_readdata = (rom_offset < 32'd128) ? rom[rom_offset[6:2]] : 32'h0000_0000;

  // data ram reads combinationally while data_read is high
  assign data_readdata = data_read ? ram[data_address[9:2]] : 32'h0000_0000;

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        ram[i] <= 32'h0000_0000;
      end
      ram[64] <= operand_a; // 0x100
      ram[65] <= operand_b; // 0x104
    end else if (data_write && clk_enable) begin
      ram[data_address[9:2]] <= data_writedata;
    end
  end

  mips_cpu_harvard #(
    .reset_vector (reset_vector)
  ) UUT (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_read      (data_read),
    .data_write     (data_write),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata),
    .register_v0    (register_v0),
    .active         (active)
  );

  bind mips_cpu_harvard mips_cpu_checker #(.reset_vector(reset_vector)) checks (
    .clk           (clk),
    .reset         (reset),
    .clk_enable    (clk_enable),
    .instr_address (instr_address),
    .data_address  (data_address),
    .data_read     (data_read),
    .data_write    (data_write),
    .active        (active)
  );

  function automatic logic [31:0] r_instr(input funct_t funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] shamt);
    return {OP_SPECIAL, rs, rt, rd, shamt, funct};
  endfunction

  function automatic logic [31:0] i_instr(input opcode_t op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] j_instr(input logic [31:0] dest);
    return {OP_J, dest[27:2]}; // word index with upper nibble from pc+4
  endfunction

  // v0 as the program computes it with the loop adding a three times
  function automatic logic [31:0] expected_v0(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] mix;
    logic [31:0] less;
    mix  = ((a + b) & (a - b)) ^ (a | b);
    less = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    return (mix << 3) + less + (32'd3 * a);
  endfunction

  function automatic logic random_enable();
    return ($urandom() % 4) != 0; // low about one cycle in four
  endfunction

  task automatic load_program();
    for (int i = 0; i < 32; i++) begin
      rom[i] = 32'h0000_0000;
    end
    rom[0]  = i_instr(OP_LW, 5'd0, 5'd8, 16'h0100);         // t0 = a
    rom[1]  = i_instr(OP_LW, 5'd0, 5'd9, 16'h0104);         // t1 = b
    rom[2]  = r_instr(FN_ADDU, 5'd8, 5'd9, 5'd10, 5'd0);
    rom[3]  = r_instr(FN_SUBU, 5'd8, 5'd9, 5'd11, 5'd0);
    rom[4]  = r_instr(FN_AND, 5'd10, 5'd11, 5'd12, 5'd0);
    rom[5]  = r_instr(FN_OR, 5'd8, 5'd9, 5'd13, 5'd0);
    rom[6]  = r_instr(FN_XOR, 5'd12, 5'd13, 5'd14, 5'd0);
    rom[7]  = r_instr(FN_SLT, 5'd8, 5'd9, 5'd15, 5'd0);     // signed a < b
    rom[8]  = r_instr(FN_SLL, 5'd0, 5'd14, 5'd16, 5'd3);
    rom[9]  = r_instr(FN_ADDU, 5'd16, 5'd15, 5'd2, 5'd0);   // first v0
    rom[10] = i_instr(OP_ADDIU, 5'd0, 5'd17, 16'd3);        // loop count
    rom[11] = r_instr(FN_ADDU, 5'd2, 5'd8, 5'd2, 5'd0);     // loop body adds a to v0
    rom[12] = i_instr(OP_ADDIU, 5'd17, 5'd17, 16'hFFFF);
    rom[13] = i_instr(OP_BNE, 5'd17, 5'd0, 16'hFFFD);       // back to 11
    rom[14] = i_instr(OP_SW, 5'd0, 5'd2, 16'h0108);
    rom[15] = j_instr(reset_vector + 32'd68);               // over the next word
    rom[16] = i_instr(OP_ADDIU, 5'd0, 5'd2, 16'd0);         // clears v0 if j falls through
    rom[17] = halt_word;
  endtask

  // drive at the rising edge and return at the falling edge
  task automatic clock_cycle(input logic enable);
    @(posedge clk);
    clk_enable <= enable;
    @(negedge clk);
  endtask

  task automatic timed_out(input string what);
    $display("timeout: %s", what);
    $display("*** FAILED ***");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("error: t=%0t %s = %h, expected %h", $time, name, got, want);
    $display("*** FAILED ***");
    $fatal(1, "result mismatch");
  endtask

  task automatic wait_for_pc_zero();
    int   count;
    logic next_enable;
    count = 0;
    while (instr_address != 32'h0000_0000) begin
      if (count == timeout_cycles) timed_out("program never jumped to address 0");
      // force a stalled edge right after the jr executes
      if (instr_readdata == halt_word) next_enable = ~clk_enable;
      else next_enable = random_enable();
      clock_cycle(next_enable);
      count++;
    end
  endtask

  task automatic wait_for_active_low();
    int count;
    count = 0;
    while (active) begin
      if (count == timeout_cycles) timed_out("active never fell after the halt");
      clock_cycle(1'b1);
      count++;
    end
  endtask

  initial begin
    logic [31:0] want;
    void'($urandom(40506));
    operand_a = $urandom();
    operand_b = $urandom();
    want      = expected_v0(operand_a, operand_b);
    load_program();
    repeat (5) @(posedge clk); // reset over five edges
    reset      <= 1'b0;
    clk_enable <= random_enable();
    @(negedge clk);
    wait_for_pc_zero();
    wait_for_active_low();
    repeat (2) clock_cycle(1'b1); // halt assertion samples pc 0 with active low
    v0_check: assert (register_v0 == want)
      else report_mismatch("register_v0", register_v0, want);
    store_check: assert (ram[66] == want)
      else report_mismatch("ram word 0x108", ram[66], want);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/mips_pkg.sv
src/ctrl_if.sv
src/alu.sv
src/reg_file.sv
src/controller.sv
src/datapath.sv
src/mips_cpu_harvard.sv
verification/mips_cpu_checker.sv
verification/mips_tb.sv
